//--- hw/eg_pkg.sv
// eg_pkg: slot count, widths, envelope state enum, write field codes, counter divider
package eg_pkg;

	////////////////////////////////
	// sizes
	localparam int NUM_SLOTS = 8;   // operator slots in rotation
	localparam int CNT_DIV   = 3;   // samples per envelope counter tick

	////////////////////////////////
	// widths with a meaning
	typedef logic [2:0]  slot_t;     // slot index
	typedef logic [9:0]  level_t;    // attenuation, 0 loudest
	typedef logic [5:0]  rate_t;     // effective rate
	typedef logic [4:0]  cfg_rate_t; // rate as written by the host
	typedef logic [3:0]  sus_t;      // sustain level
	typedef logic [6:0]  tl_t;       // total level
	typedef logic [14:0] egcnt_t;    // global envelope counter
	typedef logic [2:0]  field_t;    // host write field select

	localparam level_t LEVEL_MAX = 10'h3ff; // silence

	// envelope phases
	typedef enum logic [1:0] {
		EG_ATTACK  = 2'd0,
		EG_DECAY1  = 2'd1,
		EG_DECAY2  = 2'd2,
		EG_RELEASE = 2'd3
	} eg_state_t;

	////////////////////////////////
	// write field codes
	localparam field_t F_AR    = 3'd0; // attack rate, data[4:0]
	localparam field_t F_D1R   = 3'd1; // decay1 rate, data[4:0]
	localparam field_t F_D2R   = 3'd2; // decay2 rate, data[4:0]
	localparam field_t F_RR_SL = 3'd3; // {sl, rr}
	localparam field_t F_TL    = 3'd4; // total level, data[6:0]
	localparam field_t F_KEYON = 3'd5; // key on, data[0]

endpackage

//--- hw/eg_timer.sv
// eg_timer: slot rotation counter, last slot pulse, divided global envelope counter
`timescale 1ns/1ns

module eg_timer import eg_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   clk_en,
	output slot_t  slot,
	output logic   zero,
	output egcnt_t eg_cnt
);

	logic [1:0] div; // sample count within one eg tick
	logic       last_slot;
	logic       div_wrap;

	// last slot of the sample
	assign last_slot = (slot == slot_t'(NUM_SLOTS - 1));
	assign zero      = clk_en & last_slot; // only while the slot is serviced
	assign div_wrap  = (div == 2'(CNT_DIV - 1));

	////////////////////////////////
	// slot rotation
	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
		end else if (clk_en) begin
			if (last_slot)
				slot <= '0; // wrap
			else
				slot <= slot + 1'b1;
		end
	end

	////////////////////////////////
	// envelope counter, once per CNT_DIV samples
	always_ff @(posedge clk) begin
		if (rst) begin
			div    <= '0;
			eg_cnt <= '0;
		end else if (zero) begin
			if (div_wrap) begin
				div    <= '0;
				eg_cnt <= eg_cnt + 1'b1; // free running, wraps
			end else begin
				div <= div + 1'b1;
			end
		end
	end

endmodule

//--- hw/eg_regs.sv
// eg_regs: per-slot envelope settings written by the host, async read by slot
`timescale 1ns/1ns

module eg_regs import eg_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      wr,
	input  slot_t     wr_slot,
	input  field_t    wr_field,
	input  logic [7:0] wr_data,
	input  slot_t     rd_slot,
	output cfg_rate_t ar,
	output cfg_rate_t d1r,
	output cfg_rate_t d2r,
	output logic [3:0] rr,
	output sus_t      sl,
	output tl_t       tl,
	output logic      keyon
);

	// one array per field
	cfg_rate_t  ar_mem    [NUM_SLOTS];
	cfg_rate_t  d1r_mem   [NUM_SLOTS];
	cfg_rate_t  d2r_mem   [NUM_SLOTS];
	logic [3:0] rr_mem    [NUM_SLOTS];
	sus_t       sl_mem    [NUM_SLOTS];
	tl_t        tl_mem    [NUM_SLOTS];
	logic       keyon_mem [NUM_SLOTS];

	////////////////////////////////
	// host writes, independent of clk_en
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				ar_mem[i]    <= '0;
				d1r_mem[i]   <= '0;
				d2r_mem[i]   <= '0;
				rr_mem[i]    <= '0;
				sl_mem[i]    <= '0;
				tl_mem[i]    <= '0;
				keyon_mem[i] <= 1'b0; // all keys off
			end
		end else if (wr) begin
			case (wr_field)
				F_AR: begin
					ar_mem[wr_slot] <= wr_data[4:0];
				end
				F_D1R: begin
					d1r_mem[wr_slot] <= wr_data[4:0];
				end
				F_D2R: begin
					d2r_mem[wr_slot] <= wr_data[4:0];
				end
				F_RR_SL: begin
					rr_mem[wr_slot] <= wr_data[3:0]; // low nibble
					sl_mem[wr_slot] <= wr_data[7:4]; // high nibble
				end
				F_TL: begin
					tl_mem[wr_slot] <= wr_data[6:0];
				end
				F_KEYON: begin
					keyon_mem[wr_slot] <= wr_data[0];
				end
				default: begin
					// unused codes ignored
				end
			endcase
		end
	end

	////////////////////////////////
	// current slot fields
	assign ar    = ar_mem[rd_slot];
	assign d1r   = d1r_mem[rd_slot];
	assign d2r   = d2r_mem[rd_slot];
	assign rr    = rr_mem[rd_slot];
	assign sl    = sl_mem[rd_slot];
	assign tl    = tl_mem[rd_slot];
	assign keyon = keyon_mem[rd_slot];

endmodule

//--- hw/eg_rate.sv
// effective rate, counter window select, step pattern and increment size
`timescale 1ns/1ns

module eg_rate import eg_pkg::*; (
	input  cfg_rate_t  cfg,
	input  eg_state_t  state,
	input  egcnt_t     eg_cnt,
	output logic       step,
	output logic [3:0] inc
);

	rate_t      rate;     // doubled configured rate
	logic [3:0] shift;    // counter window position
	egcnt_t     cnt_shr;
	logic [2:0] cnt_sel;  // window of eg_cnt
	logic [7:0] pattern;  // step pattern over eight ticks
	logic       pat_bit;
	logic       is_att;

	assign rate   = {cfg, 1'b0};
	assign is_att = (state == EG_ATTACK);

	////////////////////////////////
	// window select with attack one bit faster
	always_comb begin
		if (is_att)
			shift = (rate[5:2] >= 4'd11) ? 4'd0 : 4'd11 - rate[5:2];
		else
			shift = (rate[5:2] >= 4'd12) ? 4'd0 : 4'd12 - rate[5:2];
		cnt_shr = eg_cnt >> shift;
		cnt_sel = cnt_shr[2:0];
	end

	// step patterns
	always_comb begin
		if (rate[5:4] == 2'b11) begin
			case (rate[1:0])
				2'd0:    pattern = 8'b0000_0000;
				2'd1:    pattern = 8'b1000_1000;
				2'd2:    pattern = 8'b1010_1010;
				default: pattern = 8'b1110_1110;
			endcase
		end else if (rate[5:2] == 4'd0 && !is_att) begin
			pattern = 8'b1111_1110; // slowest decay
		end else begin
			case (rate[1:0])
				2'd0:    pattern = 8'b1010_1010;
				2'd1:    pattern = 8'b1110_1010;
				2'd2:    pattern = 8'b1110_1110;
				default: pattern = 8'b1111_1110;
			endcase
		end
	end

	assign pat_bit = pattern[cnt_sel];

	////////////////////////////////
	// step flag and size
	always_comb begin
		case (rate[5:2])
			4'd12:   inc = pat_bit ? 4'd2 : 4'd1;
			4'd13:   inc = pat_bit ? 4'd4 : 4'd2;
			4'd14:   inc = pat_bit ? 4'd8 : 4'd4;
			4'd15:   inc = 4'd8;
			default: inc = 4'd1;
		endcase
		if (cfg == '0)
			step = 1'b0; // rate 0 holds the level
		else if (rate[5:4] == 2'b11)
			step = 1'b1; // top rates move every tick
		else
			step = pat_bit;
	end

endmodule

//--- hw/eg_core.sv
// eg_core: per-slot state and level memory, attack/decay/release update, tl sum
`timescale 1ns/1ns

module eg_core import eg_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  slot_t      slot,
	input  cfg_rate_t  ar,
	input  cfg_rate_t  d1r,
	input  cfg_rate_t  d2r,
	input  logic [3:0] rr,
	input  sus_t       sl,
	input  tl_t        tl,
	input  logic       keyon,
	input  logic       step,
	input  logic [3:0] inc,
	output cfg_rate_t  rate_sel,
	output eg_state_t  state_cur,
	output level_t     eg_out,
	output slot_t      eg_slot,
	output logic       eg_valid
);

	eg_state_t state_mem [NUM_SLOTS];
	level_t    level_mem [NUM_SLOTS];
	logic      kon_mem   [NUM_SLOTS]; // keyon seen on last visit

	level_t    lvl_cur;
	logic      kon_last;
	logic      kon_on;  // keyon edge
	logic      kon_off; // keyoff edge
	logic [4:0] sl_lim;
	logic [9:0] ar_base;
	logic [10:0] ar_dec;
	logic [10:0] dec_sum;
	level_t    ar_lvl;
	level_t    dec_lvl;
	eg_state_t st_nxt;
	level_t    lvl_nxt;

	// output stage
	level_t    lvl_q;
	tl_t       tl_q;
	slot_t     slot_q;
	logic      vld_q;
	logic [10:0] out_sum;

	assign state_cur = state_mem[slot];
	assign lvl_cur   = level_mem[slot];
	assign kon_last  = kon_mem[slot];
	assign kon_on    = keyon & ~kon_last;
	assign kon_off   = ~keyon & kon_last;
	assign sl_lim    = (sl == 4'd15) ? 5'd31 : {1'b0, sl}; // 15 means bottom

	// rate for the current phase
	always_comb begin
		case (state_cur)
			EG_ATTACK: rate_sel = ar;
			EG_DECAY1: rate_sel = d1r;
			EG_DECAY2: rate_sel = d2r;
			default:   rate_sel = {rr, 1'b1}; // release, doubled plus one
		endcase
	end

	////////////////////////////////
	// level arithmetic
	always_comb begin
		ar_base = {4'd0, lvl_cur[9:4]} + 10'd1; // fraction of level, never 0
		ar_dec  = 11'(ar_base) * 11'(inc);
		ar_lvl  = (ar_dec >= {1'b0, lvl_cur}) ? '0 : lvl_cur - ar_dec[9:0];
		dec_sum = {1'b0, lvl_cur} + {7'd0, inc};
		dec_lvl = dec_sum[10] ? LEVEL_MAX : dec_sum[9:0]; // saturate
	end

	////////////////////////////////
	// next state and level
	always_comb begin
		st_nxt  = state_cur;
		lvl_nxt = lvl_cur;
		if (kon_off) begin
			st_nxt = EG_RELEASE;
		end else if (kon_on) begin
			st_nxt = EG_ATTACK;
			if (ar == 5'd31)
				lvl_nxt = '0; // instant attack
		end else begin
			case (state_cur)
				EG_ATTACK: begin
					if (lvl_cur == '0)
						st_nxt = EG_DECAY1; // peak reached
					else if (ar == 5'd31)
						lvl_nxt = '0;
					else if (step)
						lvl_nxt = ar_lvl;
				end
				EG_DECAY1: begin
					if (lvl_cur[9:5] >= sl_lim)
						st_nxt = EG_DECAY2; // sustain reached
					else if (step)
						lvl_nxt = dec_lvl;
				end
				default: begin
					if (step)
						lvl_nxt = dec_lvl; // decay2 and release
				end
			endcase
		end
	end

	// per-slot memories
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_SLOTS; i++) begin
				state_mem[i] <= EG_RELEASE;
				level_mem[i] <= LEVEL_MAX; // silent
				kon_mem[i]   <= 1'b0;
			end
		end else if (clk_en) begin
			state_mem[slot] <= st_nxt;
			level_mem[slot] <= lvl_nxt;
			kon_mem[slot]   <= keyon;
		end
	end

	////////////////////////////////
	// output, one clk after the update
	always_ff @(posedge clk) begin
		if (clk_en) begin
			lvl_q  <= lvl_nxt;
			tl_q   <= tl; // tl of the serviced slot
			slot_q <= slot;
		end
		eg_slot <= slot_q;
		eg_out  <= out_sum[10] ? LEVEL_MAX : out_sum[9:0];
	end

	assign out_sum = {1'b0, lvl_q} + {1'b0, tl_q, 3'd0}; // tl x 8

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_q    <= 1'b0;
			eg_valid <= 1'b0;
		end else begin
			vld_q    <= clk_en;
			eg_valid <= vld_q; // single clk pulse
		end
	end

endmodule

//--- hw/eg_top.sv
// eg_top: envelope generator top, timer, host registers, rate logic and core
`timescale 1ns/1ns

module eg_top import eg_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic       clk_en,
	input  logic       wr,
	input  slot_t      wr_slot,
	input  field_t     wr_field,
	input  logic [7:0] wr_data,
	output level_t     eg_out,
	output slot_t      eg_slot,
	output logic       eg_valid,
	output logic       zero
);

	slot_t      slot;     // slot in service
	egcnt_t     eg_cnt;
	cfg_rate_t  ar, d1r, d2r;
	logic [3:0] rr;
	sus_t       sl;
	tl_t        tl;
	logic       keyon;
	cfg_rate_t  rate_sel; // rate of the current phase
	eg_state_t  state_cur;
	logic       step;
	logic [3:0] inc;

	////////////////////////////////
	eg_timer eg_timer_i (
		.clk    (clk),
		.rst    (rst),
		.clk_en (clk_en),
		.slot   (slot),
		.zero   (zero),
		.eg_cnt (eg_cnt)
	);

	eg_regs eg_regs_i (
		.clk      (clk),
		.rst      (rst),
		.wr       (wr),
		.wr_slot  (wr_slot),
		.wr_field (wr_field),
		.wr_data  (wr_data),
		.rd_slot  (slot),
		.ar       (ar),
		.d1r      (d1r),
		.d2r      (d2r),
		.rr       (rr),
		.sl       (sl),
		.tl       (tl),
		.keyon    (keyon)
	);

	eg_rate eg_rate_i (
		.cfg    (rate_sel),
		.state  (state_cur),
		.eg_cnt (eg_cnt),
		.step   (step),
		.inc    (inc)
	);

	eg_core eg_core_i (
		.clk       (clk),
		.rst       (rst),
		.clk_en    (clk_en),
		.slot      (slot),
		.ar        (ar),
		.d1r       (d1r),
		.d2r       (d2r),
		.rr        (rr),
		.sl        (sl),
		.tl        (tl),
		.keyon     (keyon),
		.step      (step),
		.inc       (inc),
		.rate_sel  (rate_sel),
		.state_cur (state_cur),
		.eg_out    (eg_out),
		.eg_slot   (eg_slot),
		.eg_valid  (eg_valid)
	);

endmodule

//--- tests/tb_eg.sv
// testbench for eg_top with clock and reset, lfsr stimulus, host writes and output checks
`timescale 1ns/1ns

module tb_eg;
	import eg_pkg::*;

	localparam int TIMEOUT_CYCLES = 200000; // slow release sweep plus margin
	localparam logic [31:0] SEED = 32'h43c0_f3de;

	// per-slot check modes
	localparam int M_SKIP   = 0;
	localparam int M_CONST  = 1;
	localparam int M_NONDEC = 2; // decay and release
	localparam int M_NONINC = 3; // attack up to level 0

	logic       clk;
	logic       rst;
	logic       clk_en;
	logic       wr;
	slot_t      wr_slot;
	field_t     wr_field;
	logic [7:0] wr_data;
	level_t     eg_out;
	slot_t      eg_slot;
	logic       eg_valid;
	logic       zero;

	logic [31:0] en_lfsr;   // clk_en source
	logic [31:0] data_lfsr; // field values
	logic        en_d1;
	logic        en_d2;     // clk_en of the update cycle
	logic        zero_d1;
	logic        zero_d2;   // zero of the update cycle
	int          mode [NUM_SLOTS];
	level_t      exp_val [NUM_SLOTS];
	level_t      last_val [NUM_SLOTS];
	logic [3:0]  sl_v [NUM_SLOTS];
	logic        att_done [NUM_SLOTS];
	slot_t       exp_slot;
	int          samples;  // completed rotations
	int          cycles;

	eg_top eg_top_i (
		.clk      (clk),
		.rst      (rst),
		.clk_en   (clk_en),
		.wr       (wr),
		.wr_slot  (wr_slot),
		.wr_field (wr_field),
		.wr_data  (wr_data),
		.eg_out   (eg_out),
		.eg_slot  (eg_slot),
		.eg_valid (eg_valid),
		.zero     (zero)
	);

	always #2 clk = ~clk;

	//////////////////////////////
	// helpers
	function automatic logic [31:0] lfsr_step(input logic [31:0] x);
		return {1'b0, x[31:1]} ^ (x[0] ? 32'h8020_0003 : 32'h0); // galois with taps 32 22 2 1
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			data_lfsr = lfsr_step(data_lfsr); // one step per bit
			v[i] = data_lfsr[0];
		end
	endtask

	function automatic level_t cap_level(input int v);
		return (v > 'h3ff) ? 10'h3ff : level_t'(v);
	endfunction

	task automatic report_mismatch(input string name, input int s, input int got, input int exp);
		$display("** FAIL **");
		$display("Mismatch %s slot %0d: got %h expected %h", name, s, got, exp);
		$fatal(1);
	endtask

	task automatic write_reg(input int s, input field_t f, input logic [7:0] d);
		@(posedge clk);
		wr       <= 1'b1;
		wr_slot  <= slot_t'(s);
		wr_field <= f;
		wr_data  <= d;
		@(posedge clk);
		wr <= 1'b0; // single clk strobe
	endtask

	task automatic wait_samples(input int n);
		int target;
		target = samples + n;
		while (samples < target)
			@(posedge clk);
	endtask

	// final level must lie in the sustain band with tl 0
	task automatic check_sustain(input int s);
		int lo;
		int hi;
		lo = (sl_v[s] == 4'd15) ? 'h3e0 : sl_v[s] * 32;
		hi = (sl_v[s] == 4'd15) ? 'h400 : sl_v[s] * 32 + 32;
		assert (last_val[s] >= lo && last_val[s] < hi)
			else report_mismatch("eg_out", s, last_val[s], lo);
		exp_val[s] = last_val[s];
		mode[s]    = M_CONST; // settled
	endtask

	//////////////////////////////
	// clk_en and pipelines of clk_en and zero
	always @(posedge clk) begin
		en_lfsr = lfsr_step(en_lfsr);
		clk_en  <= en_lfsr[0]; // about half the cycles
		en_d1   <= clk_en & ~rst;
		en_d2   <= en_d1;
		zero_d1 <= zero;
		zero_d2 <= zero_d1;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("** FAIL **");
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$fatal(1);
		end
	end

	//////////////////////////////
	// output checks at mid cycle
	always @(negedge clk) begin
		int s;
		if (!rst) begin
			assert (eg_valid == en_d2)
				else report_mismatch("eg_valid", int'(eg_slot), eg_valid, en_d2);
		end
		if (!rst && eg_valid) begin
			s = int'(eg_slot);
			assert (eg_slot == exp_slot)
				else report_mismatch("eg_slot", s, eg_slot, exp_slot);
			assert (zero_d2 == (eg_slot == slot_t'(NUM_SLOTS - 1)))
				else report_mismatch("zero", s, zero_d2, !zero_d2);
			case (mode[s])
				M_CONST: begin
					assert (eg_out == exp_val[s])
						else report_mismatch("eg_out", s, eg_out, exp_val[s]);
				end
				M_NONDEC: begin
					assert (eg_out >= last_val[s])
						else report_mismatch("eg_out", s, eg_out, last_val[s]);
				end
				M_NONINC: begin
					assert (eg_out <= last_val[s])
						else report_mismatch("eg_out", s, eg_out, last_val[s]);
					if (eg_out == '0) begin
						att_done[s] = 1'b1; // peak reached so decay follows
						mode[s]     = M_NONDEC;
					end
				end
				default: ;
			endcase
			last_val[s] = eg_out;
			exp_slot    = exp_slot + 1'b1;
			if (s == NUM_SLOTS - 1)
				samples++;
		end
	end

	//////////////////////////////
	// stimulus
	initial begin
		logic [7:0] v;
		clk = 1'b0;
		rst = 1'b1;
		clk_en = 1'b0;
		wr = 1'b0;
		wr_slot = '0;
		wr_field = '0;
		wr_data = '0;
		en_lfsr = SEED;
		data_lfsr = SEED;
		en_d1 = 1'b0;
		en_d2 = 1'b0;
		zero_d1 = 1'b0;
		zero_d2 = 1'b0;
		exp_slot = '0;
		samples = 0;
		cycles = 0;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			mode[s]     = M_CONST; // silence after reset
			exp_val[s]  = 10'h3ff;
			last_val[s] = 10'h3ff;
			sl_v[s]     = '0;
			att_done[s] = 1'b0;
		end
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		wait_samples(4);

		// instant attack with random tl
		for (int s = 0; s < NUM_SLOTS; s++) begin
			take_bits(7, v);
			mode[s] = M_SKIP;
			write_reg(s, F_AR, 8'd31);
			write_reg(s, F_D1R, 8'd0);
			write_reg(s, F_D2R, 8'd0);
			write_reg(s, F_TL, v);
			write_reg(s, F_KEYON, 8'd1);
			wait_samples(2);
			exp_val[s] = cap_level(int'(v[6:0]) * 8);
			mode[s]    = M_CONST;
		end
		wait_samples(4);

		// decay to a random sustain level on slots 0..3
		for (int s = 0; s < 4; s++) begin
			take_bits(4, v);
			sl_v[s] = v[3:0];
			mode[s] = M_SKIP;
			write_reg(s, F_KEYON, 8'd0);
			wait_samples(2); // keyoff seen
			write_reg(s, F_TL, 8'd0);
			write_reg(s, F_D1R, 8'd31);
			write_reg(s, F_RR_SL, {sl_v[s], 4'd0});
			write_reg(s, F_KEYON, 8'd1);
			wait_samples(2);
			mode[s] = M_NONDEC;
		end
		wait_samples(200);
		for (int s = 0; s < 4; s++)
			check_sustain(s);

		// release on slots 4..7
		for (int s = 4; s < NUM_SLOTS; s++) begin
			take_bits(3, v);
			write_reg(s, F_RR_SL, {4'd0, 4'd8 + {1'b0, v[2:0]}});
			mode[s] = M_NONDEC;
			write_reg(s, F_KEYON, 8'd0);
		end
		while (!(last_val[4] == 10'h3ff && last_val[5] == 10'h3ff &&
				last_val[6] == 10'h3ff && last_val[7] == 10'h3ff))
			wait_samples(1);
		for (int s = 4; s < NUM_SLOTS; s++) begin
			exp_val[s] = 10'h3ff;
			mode[s]    = M_CONST;
		end
		wait_samples(4);

		// slot 4 without tl keeps releasing until the bare level is silent
		mode[4] = M_SKIP;
		write_reg(4, F_TL, 8'd0);
		wait_samples(2);
		mode[4] = M_NONDEC;
		while (last_val[4] != 10'h3ff)
			wait_samples(1);
		exp_val[4] = 10'h3ff;
		mode[4]    = M_CONST;
		wait_samples(2);

		// finite attack from silence on slot 4
		take_bits(4, v);
		sl_v[4] = v[3:0];
		write_reg(4, F_AR, 8'd20);
		write_reg(4, F_D1R, 8'd31);
		write_reg(4, F_RR_SL, {sl_v[4], 4'd8});
		att_done[4] = 1'b0;
		mode[4]     = M_NONINC;
		write_reg(4, F_KEYON, 8'd1);
		while (!att_done[4])
			wait_samples(1);
		wait_samples(200);
		check_sustain(4);
		wait_samples(4);

		$display("** PASS **");
		$finish;
	end

endmodule

//--- compile.f
hw/eg_pkg.sv
hw/eg_timer.sv
hw/eg_regs.sv
hw/eg_rate.sv
hw/eg_core.sv
hw/eg_top.sv
tests/tb_eg.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the envelope generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary -Wno-fatal -f compile.f --top-module tb_eg -o tb_eg
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_eg > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -qF '** FAIL **' "$LOG"; then
	echo "simulation failed"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -qF '** PASS **' "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
